//--- rtl/fp_types_pkg.sv
// binary32 field widths, rounding modes and multiplier stage structs
package fp_types_pkg;

    localparam int EXP_W    = 8;
    localparam int MAN_W    = 23;
    localparam int EXP_BIAS = 127;
    localparam int FP_W     = 1 + EXP_W + MAN_W;

    localparam logic [FP_W-1:0] CANON_NAN = 32'h7FC0_0000;

    // codes 5 to 7 round as rne
    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,
        RM_RUP = 3'd3,
        RM_RMM = 3'd4
    } rnd_mode_e;

    typedef struct packed {
        logic              sign;
        logic signed [9:0] expo;  // biased, below 1 for normalized subnormals
        logic              zero;
        logic              inf;
        logic              snan;
        logic              qnan;
        logic [MAN_W:0]    mant;  // hidden bit on top
    } fp_class_t;

    typedef struct packed {
        logic            valid;
        logic [FP_W-1:0] opa;
        logic [FP_W-1:0] opb;
        logic            neg;
        rnd_mode_e       rm;
    } fp_mul_in_t;

    typedef struct packed {
        logic              valid;
        logic              sign;
        logic signed [9:0] expo;
        logic [MAN_W+1:0]  mant;  // top bit catches the rounding carry
        logic [2:0]        grs;
        rnd_mode_e         rm;
        logic              snan;
        logic              qnan;
        logic              inf;
        logic              zero;
        logic              diff;
        logic              dbz;
    } fp_rnd_in_t;

    typedef struct packed {
        logic            ready;
        logic [FP_W-1:0] result;
        logic [4:0]      flags;  // nv dz of uf nx
    } fp_rnd_out_t;

endpackage

//--- rtl/apb_regs_pkg.sv
// apb request and response structs, register map, opcodes and control states
package apb_regs_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [4:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [4:0] REG_OPA    = 5'h00;
    localparam logic [4:0] REG_OPB    = 5'h04;
    localparam logic [4:0] REG_CTRL   = 5'h08;
    localparam logic [4:0] REG_RESULT = 5'h0C;  // read only
    localparam logic [4:0] REG_STATUS = 5'h10;  // read only

    localparam int CTRL_OP_BIT    = 0;
    localparam int CTRL_RM_LSB    = 1;
    localparam int CTRL_START_BIT = 8;

    typedef enum logic {OP_FMUL = 1'b0, OP_FNMUL = 1'b1} fpu_op_e;

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_DONE} ctrl_state_e;

endpackage

//--- rtl/fp_unpack.sv
// operand classifier and field extraction for both multiplier inputs
`timescale 1ns/100ps

module fp_unpack
    import fp_types_pkg::*;
(
    input  fp_mul_in_t req_i,
    output fp_class_t  opa_o,
    output fp_class_t  opb_o
);

    function automatic fp_class_t classify(input logic [FP_W-1:0] op);
        fp_class_t        c;
        logic [EXP_W-1:0] e;
        logic [MAN_W-1:0] f;
        logic [4:0]       lzc;
        e   = op[MAN_W +: EXP_W];
        f   = op[MAN_W-1:0];
        lzc = '0;
        // highest set bit wins
        for (int i = 0; i < MAN_W; i++) begin
            if (f[i]) begin
                lzc = 5'(MAN_W - 1 - i);
            end
        end

        c.sign = op[FP_W-1];
        c.zero = (e == '0) && (f == '0);
        c.inf  = (e == '1) && (f == '0);
        c.snan = (e == '1) && (f != '0) && !f[MAN_W-1];
        c.qnan = (e == '1) && f[MAN_W-1];

        if (e == '0) begin
            // subnormal, bring the leading one up to the hidden bit
            c.mant = {1'b0, f} << (lzc + 5'd1);
            c.expo = -10'(lzc);
        end else begin
            c.mant = {1'b1, f};
            c.expo = {2'b00, e};
        end
        return c;
    endfunction

    assign opa_o = classify(req_i.opa);
    assign opb_o = classify(req_i.opb);

endmodule

//--- rtl/fp_mul.sv
// significand multiplier with exponent sum, normalization and special decode
`timescale 1ns/100ps

module fp_mul
    import fp_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  fp_mul_in_t req_i,
    input  fp_class_t  opa_i,
    input  fp_class_t  opb_i,
    output fp_rnd_in_t rnd_o
);

    logic [47:0]       prod;
    logic [47:0]       norm;
    logic [47:0]       shifted;
    logic signed [9:0] expo_sum;
    logic signed [9:0] expo_n;
    logic signed [9:0] expo_out;
    logic [9:0]        sh_full;
    logic [5:0]        sh;
    logic              lost;
    fp_rnd_in_t        rnd_d;
    fp_rnd_in_t        rnd_q;
    logic              valid_q;

    assign prod = opa_i.mant * opb_i.mant;

    always_comb begin
        expo_sum = opa_i.expo + opb_i.expo - 10'(EXP_BIAS);

        // product is in [1,4), at most one bit of normalization
        if (prod[47]) begin
            norm   = prod;
            expo_n = expo_sum + 10'sd1;
        end else begin
            norm   = prod << 1;
            expo_n = expo_sum;
        end

        sh_full  = 10'sd1 - expo_n;
        sh       = (sh_full > 10'd48) ? 6'd48 : sh_full[5:0];
        shifted  = norm;
        lost     = 1'b0;
        expo_out = expo_n;
        if (expo_n < 10'sd1) begin
            // tiny, denormalize and keep what falls off as sticky
            shifted  = norm >> sh;
            lost     = |(norm & ~({48{1'b1}} << sh));
            expo_out = '0;
        end

        rnd_d.valid = req_i.valid;
        rnd_d.sign  = opa_i.sign ^ opb_i.sign ^ req_i.neg;
        rnd_d.expo  = expo_out;
        rnd_d.mant  = {1'b0, shifted[47:24]};
        rnd_d.grs   = {shifted[23], shifted[22], (|shifted[21:0]) | lost};
        rnd_d.rm    = req_i.rm;
        // 0 * inf is invalid, reported like an snan
        rnd_d.snan  = opa_i.snan | opb_i.snan | (opa_i.zero & opb_i.inf) |
                      (opa_i.inf & opb_i.zero);
        rnd_d.qnan  = opa_i.qnan | opb_i.qnan;
        rnd_d.inf   = opa_i.inf | opb_i.inf;
        rnd_d.zero  = opa_i.zero | opb_i.zero;
        rnd_d.diff  = 1'b0;  // product zeros always carry the xor sign
        rnd_d.dbz   = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rnd_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        rnd_q <= rnd_d;
    end

    always_comb begin
        rnd_o       = rnd_q;
        rnd_o.valid = valid_q;
    end

endmodule

//--- rtl/fp_rnd.sv
// rounding stage with overflow, underflow, special results and flag packing
`timescale 1ns/100ps

module fp_rnd
    import fp_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  fp_rnd_in_t  fp_rnd_i,
    output fp_rnd_out_t fp_rnd_o
);

    fp_rnd_in_t        in_q;
    logic              valid_q;
    logic              sign;
    logic signed [9:0] expo;
    logic [MAN_W+1:0]  mant;
    logic              inexact;
    logic              rndup;
    logic              rnddn;
    logic [FP_W-1:0]   result;
    logic [4:0]        flags;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fp_rnd_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        in_q <= fp_rnd_i;
    end

    always_comb begin
        sign    = in_q.sign;
        expo    = in_q.expo;
        inexact = |in_q.grs;
        rndup   = 1'b0;
        rnddn   = 1'b0;

        case (in_q.rm)
            RM_RTZ: rnddn = 1'b1;
            RM_RDN: begin
                if (sign && inexact) begin
                    rndup = 1'b1;
                end else if (!sign && in_q.zero && in_q.diff) begin
                    sign = 1'b1;
                end else if (!sign) begin
                    rnddn = 1'b1;
                end
            end
            RM_RUP: begin
                if (!sign && inexact) begin
                    rndup = 1'b1;
                end else if (sign) begin
                    rnddn = 1'b1;
                end
            end
            RM_RMM: rndup = in_q.grs[2];
            default: rndup = in_q.grs[2] & (in_q.mant[0] | (|in_q.grs[1:0]));
        endcase

        mant = in_q.mant + {{(MAN_W+1){1'b0}}, rndup};

        // subnormal rounding into the smallest normal
        if (rndup && expo == 10'sd0 && mant[MAN_W]) begin
            expo = 10'sd1;
        end
        if (mant[MAN_W+1]) begin  // carry out, renormalize
            mant = mant >> 1;
            expo = expo + 10'sd1;
        end

        // tininess taken before rounding
        flags  = {3'b000, inexact && (in_q.expo == 10'sd0), inexact};
        result = {sign, expo[EXP_W-1:0], mant[MAN_W-1:0]};

        if (expo > 10'sd254) begin
            flags = 5'b00101;
            if (rnddn) begin
                // largest finite magnitude
                result = {sign, {(EXP_W-1){1'b1}}, 1'b0, {MAN_W{1'b1}}};
            end else begin
                result = {sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
            end
        end

        if (in_q.snan) begin
            result = CANON_NAN;
            flags  = 5'b10000;
        end else if (in_q.qnan) begin
            result = CANON_NAN;
            flags  = 5'b00000;
        end else if (in_q.dbz) begin
            result = {sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
            flags  = 5'b01000;
        end else if (in_q.inf) begin
            result = {sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
            flags  = 5'b00000;
        end else if (in_q.zero) begin
            result = {sign, {EXP_W{1'b0}}, {MAN_W{1'b0}}};
            flags  = 5'b00000;
        end
    end

    assign fp_rnd_o.ready  = valid_q;
    assign fp_rnd_o.result = result;
    assign fp_rnd_o.flags  = flags;

endmodule

//--- rtl/fpu_ctrl.sv
// apb register file and control fsm that launches multiplies and captures results
`timescale 1ns/100ps

module fpu_ctrl
    import fp_types_pkg::*;
    import apb_regs_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  apb_req_t    apb_req_i,
    output apb_rsp_t    apb_rsp_o,
    output fp_mul_in_t  mul_req_o,
    input  fp_rnd_out_t rnd_rsp_i
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic [31:0] opa_q;
    logic [31:0] opb_q;
    logic [31:0] result_q;
    logic [4:0]  flags_q;
    fpu_op_e     op_q;
    rnd_mode_e   rm_q;
    logic        go_q;
    logic        launch_q;
    logic        busy;
    logic        done;
    logic        access;
    logic        wr_en;
    logic        rd_en;
    logic        mapped;
    logic        ro_addr;
    logic        start_req;
    logic        start_ok;

    assign access    = apb_req_i.psel & apb_req_i.penable;
    assign wr_en     = access & apb_req_i.pwrite;
    assign rd_en     = access & ~apb_req_i.pwrite;
    assign busy      = (state_q == ST_WAIT);
    assign done      = (state_q == ST_DONE);
    assign mapped    = apb_req_i.paddr inside {REG_OPA, REG_OPB, REG_CTRL, REG_RESULT, REG_STATUS};
    assign ro_addr   = (apb_req_i.paddr == REG_RESULT) || (apb_req_i.paddr == REG_STATUS);
    assign start_req = wr_en && (apb_req_i.paddr == REG_CTRL) && apb_req_i.pwdata[CTRL_START_BIT];
    assign start_ok  = start_req & ~busy;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (start_ok) state_d = ST_WAIT;
            ST_WAIT: if (rnd_rsp_i.ready) state_d = ST_DONE;
            ST_DONE: if (start_ok) state_d = ST_WAIT;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= ST_IDLE;
            opa_q    <= '0;
            opb_q    <= '0;
            op_q     <= OP_FMUL;
            rm_q     <= RM_RNE;
            go_q     <= 1'b0;
            launch_q <= 1'b0;
            result_q <= '0;
            flags_q  <= '0;
        end else begin
            state_q  <= state_d;
            go_q     <= start_ok;
            launch_q <= go_q;  // one cycle after the start write
            if (wr_en && apb_req_i.paddr == REG_OPA) begin
                opa_q <= apb_req_i.pwdata;
            end
            if (wr_en && apb_req_i.paddr == REG_OPB) begin
                opb_q <= apb_req_i.pwdata;
            end
            if (wr_en && apb_req_i.paddr == REG_CTRL && !(start_req && busy)) begin
                op_q <= fpu_op_e'(apb_req_i.pwdata[CTRL_OP_BIT]);
                rm_q <= rnd_mode_e'(apb_req_i.pwdata[CTRL_RM_LSB +: 3]);
            end
            if (busy && rnd_rsp_i.ready) begin
                result_q <= rnd_rsp_i.result;
                flags_q  <= rnd_rsp_i.flags;
            end
        end
    end

    always_comb begin
        apb_rsp_o.prdata  = '0;
        apb_rsp_o.pready  = 1'b1;  // no wait states
        apb_rsp_o.pslverr = access & (~mapped | (wr_en & ro_addr) | (start_req & busy));
        if (rd_en) begin
            case (apb_req_i.paddr)
                REG_OPA:    apb_rsp_o.prdata = opa_q;
                REG_OPB:    apb_rsp_o.prdata = opb_q;
                REG_CTRL:   apb_rsp_o.prdata = {28'b0, rm_q, op_q};
                REG_RESULT: apb_rsp_o.prdata = result_q;
                REG_STATUS: apb_rsp_o.prdata = {25'b0, flags_q, done, busy};
                default:    apb_rsp_o.prdata = '0;
            endcase
        end
    end

    always_comb begin
        mul_req_o.valid = launch_q;
        mul_req_o.opa   = opa_q;
        mul_req_o.opb   = opb_q;
        mul_req_o.neg   = (op_q == OP_FNMUL);
        mul_req_o.rm    = rm_q;
    end

endmodule

//--- rtl/fpu_top.sv
// fpu top level with apb control and the unpack, multiply and round stages
`timescale 1ns/100ps

module fpu_top
    import fp_types_pkg::*;
    import apb_regs_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o
);

    fp_mul_in_t  mul_req;
    fp_class_t   opa_cls;
    fp_class_t   opb_cls;
    fp_rnd_in_t  rnd_req;
    fp_rnd_out_t rnd_rsp;

    fpu_ctrl fpu_ctrl_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req_i (apb_req_i),
        .apb_rsp_o (apb_rsp_o),
        .mul_req_o (mul_req),
        .rnd_rsp_i (rnd_rsp)
    );

    fp_unpack fp_unpack_inst (
        .req_i (mul_req),
        .opa_o (opa_cls),
        .opb_o (opb_cls)
    );

    fp_mul fp_mul_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (mul_req),
        .opa_i (opa_cls),
        .opb_i (opb_cls),
        .rnd_o (rnd_req)
    );

    fp_rnd fp_rnd_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .fp_rnd_i (rnd_req),
        .fp_rnd_o (rnd_rsp)
    );

endmodule

//--- sim/tb_fpu_asserts.sv
// concurrent checks on the fpu control block, bound into fpu_ctrl
`timescale 1ns/100ps

module tb_fpu_asserts (
    input logic clk,
    input logic rst_n,
    input logic launch,
    input logic busy,
    input logic done,
    input logic pready,
    input logic rnd_ready
);

    logic pending;  // launched, rounder not back yet

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (launch) begin
            pending <= 1'b1;
        end else if (rnd_ready) begin
            pending <= 1'b0;
        end
    end

    launch_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        launch |=> !launch)
        else $error("launch valid held for more than one cycle");

    // only one operation in flight
    launch_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        launch |-> busy && !pending)
        else $error("launch issued while an operation was pending");

    pready_high: assert property (@(posedge clk) disable iff (!rst_n)
        pready)
        else $error("pready dropped low");

    done_after_ready: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> $past(rnd_ready))
        else $error("done rose without a rounder ready in the cycle before");

endmodule

bind fpu_ctrl tb_fpu_asserts tb_fpu_asserts_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .launch    (mul_req_o.valid),
    .busy      (busy),
    .done      (done),
    .pready    (apb_rsp_o.pready),
    .rnd_ready (rnd_rsp_i.ready)
);

//--- sim/tb_fpu.sv
// testbench for the apb floating-point multiplier with reference model and checks
`timescale 1ns/100ps

module tb_fpu
    import apb_regs_pkg::*;
;

    localparam int    PERIOD    = 40;
    localparam int    N_RAND    = 40;
    localparam int    TOTAL_OPS = 7 * N_RAND + 100 + 50 + 2;
    localparam longint WATCH_NS = longint'(TOTAL_OPS) * 20 * PERIOD + 5000 * PERIOD;

    logic     clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    int       errors;
    int       checks;
    int       tests;
    int       tests_failed;
    int       errors_at_start;

    fpu_top fpu_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp)
    );

    always #(PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCH_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // setup cycle, access cycle, sampled mid access
    task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #2;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        expect_eq("pready", 32'(apb_rsp.pready), 32'h1);
        @(posedge clk);
        #2;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] dummy;
        apb_xfer(1'b1, addr, data, dummy, err);
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data, output logic err);
        apb_xfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    function automatic void unpack_op(input logic [31:0] x, output logic [23:0] m, output int e,
                                      output logic z, output logic inf, output logic sn,
                                      output logic qn);
        logic [22:0] frac;
        frac = x[22:0];
        e    = int'(x[30:23]);
        z    = (e == 0) && (frac == 0);
        inf  = (e == 255) && (frac == 0);
        sn   = (e == 255) && (frac != 0) && !frac[22];
        qn   = (e == 255) && frac[22];
        if (e == 0) begin
            m = {1'b0, frac};
            e = 1;
            while (m != 0 && !m[23]) begin  // scale subnormal up
                m = m << 1;
                e--;
            end
        end else begin
            m = {1'b1, frac};
        end
    endfunction

    // returns {result, flags}
    function automatic logic [36:0] ref_mul(input logic [31:0] a, input logic [31:0] b,
                                            input logic neg, input logic [2:0] rm);
        logic [23:0] ma, mb, mr;
        int          ea, eb, er, e0, sh;
        logic        za, zb, ia, ib, sna, snb, qna, qnb;
        logic [47:0] p;
        logic        sr, g, r, s, inex, up;
        logic [24:0] m25;
        logic [31:0] res;
        logic [4:0]  fl;
        unpack_op(a, ma, ea, za, ia, sna, qna);
        unpack_op(b, mb, eb, zb, ib, snb, qnb);
        sr = a[31] ^ b[31] ^ neg;
        p  = {24'b0, ma} * {24'b0, mb};
        er = ea + eb - 127;
        s  = 1'b0;
        if (p[47]) er++;
        else p = p << 1;
        if (er < 1) begin
            sh = (1 - er > 48) ? 48 : 1 - er;
            for (int i = 0; i < sh; i++) begin
                s = s | p[0];
                p = p >> 1;
            end
            er = 0;
        end
        mr   = p[47:24];
        g    = p[23];
        r    = p[22];
        s    = s | (|p[21:0]);
        inex = g | r | s;
        case (rm)
            3'd1:    up = 1'b0;
            3'd2:    up = sr & inex;
            3'd3:    up = !sr & inex;
            3'd4:    up = g;
            default: up = g & (mr[0] | r | s);
        endcase
        e0  = er;
        m25 = {1'b0, mr} + 25'(up);
        if (e0 == 0 && m25[23]) er = 1;
        if (m25[24]) begin
            m25 = m25 >> 1;
            er++;
        end
        fl  = {3'b000, inex && (e0 == 0), inex};
        res = {sr, 8'(er), m25[22:0]};
        if (er > 254) begin
            fl  = 5'b00101;
            res = (rm == 3'd1 || (rm == 3'd2 && !sr) || (rm == 3'd3 && sr)) ?
                  {sr, 8'hFE, 23'h7FFFFF} : {sr, 8'hFF, 23'h0};
        end
        if (sna || snb || (za && ib) || (ia && zb)) begin
            res = 32'h7FC0_0000;
            fl  = 5'b10000;
        end else if (qna || qnb) begin
            res = 32'h7FC0_0000;
            fl  = 5'b00000;
        end else if (ia || ib) begin
            res = {sr, 8'hFF, 23'h0};
            fl  = 5'b00000;
        end else if (za || zb) begin
            res = {sr, 31'h0};
            fl  = 5'b00000;
        end
        return {res, fl};
    endfunction

    task automatic wait_done(output logic [31:0] res, output logic [4:0] flags);
        logic [31:0] st;
        logic        err;
        int          polls;
        polls = 0;
        st    = '0;
        while (!st[1] && polls < 40) begin
            apb_read(REG_STATUS, st, err);
            polls++;
        end
        assert (st[1]) else begin
            $display("operation never completed, done stayed low");
            errors++;
        end
        flags = st[6:2];
        apb_read(REG_RESULT, res, err);
    endtask

    task automatic check_op(input logic [31:0] a, input logic [31:0] b, input logic op,
                            input logic [2:0] rm);
        logic [31:0] res;
        logic [4:0]  flags;
        logic [36:0] exp;
        logic        err;
        apb_write(REG_OPA, a, err);
        apb_write(REG_OPB, b, err);
        apb_write(REG_CTRL, (32'h1 << CTRL_START_BIT) | (32'(rm) << 1) | 32'(op), err);
        wait_done(res, flags);
        exp = ref_mul(a, b, op, rm);
        expect_eq("result", res, exp[36:5]);
        expect_eq("flags", 32'(flags), 32'(exp[4:0]));
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    function automatic logic [31:0] rand_normal();
        return {1'($urandom), 8'(1 + $urandom % 254), 23'($urandom)};
    endfunction

    logic [31:0] specials[10] = '{32'h7FC0_0001, 32'h7F80_0001, 32'h0000_0000, 32'h7F80_0000,
                                  32'hFF80_0000, 32'h8000_0000, 32'h4040_0000, 32'hC0A0_0000,
                                  32'h0000_0003, 32'h3F80_0000};
    logic [31:0] big[4]   = '{32'h7F00_0000, 32'h4000_0000, 32'hFE7F_FFFF, 32'h7F7F_FFFF};
    logic [31:0] tiny[6]  = '{32'h0080_0000, 32'h3F00_0000, 32'h0080_0001, 32'h0000_0001,
                              32'h1980_0000, 32'h2A55_5555};

    initial begin
        logic [31:0] rd;
        logic [31:0] res;
        logic [4:0]  flags;
        logic [36:0] exp;
        logic        err;
        clk             = 1'b0;
        rst_n           = 1'b0;
        apb_req         = '0;
        errors          = 0;
        checks          = 0;
        tests           = 0;
        tests_failed    = 0;
        errors_at_start = 0;
        void'($urandom(32'h1592_7fd5));
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        apb_read(REG_STATUS, rd, err);
        expect_eq("status", rd, 32'h0);
        apb_read(REG_RESULT, rd, err);
        expect_eq("result", rd, 32'h0);
        apb_write(REG_OPA, 32'hDEAD_BEEF, err);
        expect_eq("pslverr", 32'(err), 32'h0);
        apb_write(REG_OPB, 32'h1234_5678, err);
        apb_read(REG_OPA, rd, err);
        expect_eq("opa", rd, 32'hDEAD_BEEF);
        apb_read(REG_OPB, rd, err);
        expect_eq("opb", rd, 32'h1234_5678);
        apb_read(5'h14, rd, err);
        expect_eq("pslverr", 32'(err), 32'h1);
        apb_write(REG_RESULT, 32'h1, err);
        expect_eq("pslverr", 32'(err), 32'h1);
        end_test("register access and reset");

        for (int m = 0; m < 5; m++) begin
            for (int i = 0; i < N_RAND; i++) check_op(rand_normal(), rand_normal(), 1'b0, 3'(m));
        end
        end_test("random fmul in all rounding modes");

        for (int i = 0; i < 2 * N_RAND; i++) begin
            check_op(rand_normal(), rand_normal(), 1'b1, (i % 2) ? 3'd3 : 3'd2);
        end
        end_test("random fnmul under rdn and rup");

        foreach (specials[i]) begin
            foreach (specials[j]) check_op(specials[i], specials[j], 1'b0, 3'd0);
        end
        // zero times infinity straight against the canonical nan
        apb_write(REG_OPA, 32'h0000_0000, err);
        apb_write(REG_OPB, 32'h7F80_0000, err);
        apb_write(REG_CTRL, 32'h1 << CTRL_START_BIT, err);
        wait_done(res, flags);
        expect_eq("nan result", res, 32'h7FC0_0000);
        expect_eq("invalid flags", 32'(flags), 32'h10);
        end_test("special operands");

        for (int m = 0; m < 5; m++) begin
            foreach (big[i]) check_op(big[i], big[(i + 1) % 4], 1'b0, 3'(m));
            foreach (tiny[i]) check_op(tiny[i], tiny[(i + 1) % 6], 1'b0, 3'(m));
        end
        end_test("overflow and underflow");

        apb_write(REG_OPA, 32'h3FC0_0001, err);
        apb_write(REG_OPB, 32'h4055_5555, err);
        apb_write(REG_CTRL, 32'h1 << CTRL_START_BIT, err);
        apb_write(REG_CTRL, (32'h1 << CTRL_START_BIT) | 32'h7, err);
        expect_eq("pslverr", 32'(err), 32'h1);
        wait_done(res, flags);
        exp = ref_mul(32'h3FC0_0001, 32'h4055_5555, 1'b0, 3'd0);
        expect_eq("result", res, exp[36:5]);
        expect_eq("flags", 32'(flags), 32'(exp[4:0]));
        apb_read(REG_CTRL, rd, err);
        expect_eq("ctrl", 32'(rd[3:0]), 32'h0);  // opcode and mode kept
        end_test("start while busy");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/fp_types_pkg.sv
rtl/apb_regs_pkg.sv
rtl/fp_unpack.sv
rtl/fp_mul.sv
rtl/fp_rnd.sv
rtl/fpu_ctrl.sv
rtl/fpu_top.sv
sim/tb_fpu_asserts.sv
sim/tb_fpu.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_fpu -o tb_fpu \
    > build.log 2>&1 \
    && ./obj_dir/tb_fpu > sim.log 2>&1
grep -qx "ALL TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
